/* logic/display_data_select.sv */
`timescale 1ns/10ps
// display word builder
module display_data_select (
  input  logic                        clock,
  input  logic                        reset,
  engine_status_if.sink               status,
  input  logic                        rtry_capture,
  input  logic                        latch_capture,
  input  display_pkg::latch_group_t   latch_group,
  output display_pkg::display_word_t  display_data
);

  display_pkg::display_word_t word_d;
  logic [4:0]                 cmd_bits;

  // ----------------------------------------
  // command kind as one-hot flags
  // ----------------------------------------
  always_comb
  begin
    case (status.cmd_kind)
      display_pkg::cmd_intrpt:     cmd_bits = 5'b00001;
      display_pkg::cmd_wkhstthrd:  cmd_bits = 5'b00010;
      display_pkg::cmd_atomic_ld:  cmd_bits = 5'b00100;
      display_pkg::cmd_atomic_st:  cmd_bits = 5'b01000;
      display_pkg::cmd_atomic_cas: cmd_bits = 5'b10000;
      default:                     cmd_bits = 5'b00000;  // cmd_none
    endcase
  end

  // ----------------------------------------
  // word mux
  // ----------------------------------------
  always_comb
  begin
    word_d = '0;  // unlisted bits read zero
    if (rtry_capture)
    begin
      word_d[29:28] = status.rtry_queue_rddata[17:16];
      word_d[27]    = status.rtry_queue_rden_blocker;
      word_d[24:20] = status.pending_cnt;
      word_d[19:16] = status.resp_code;
      word_d[15:0]  = status.rtry_queue_rddata[15:0];
    end
    else if (latch_capture)
    begin
      case (latch_group)
        display_pkg::grp_status:
        begin
          word_d[63:53] = status.rtry_queue_wraddr;
          word_d[52:42] = status.rtry_queue_rdaddr;
          word_d[41]    = |status.pending_cnt;
          word_d[40]    = status.rtry_queue_rden_blocker;
          word_d[39:32] = ~status.unit_idle;   // busy, unit 7 on top
          word_d[31:24] = status.unit_wt4rsp;
          word_d[4:0]   = cmd_bits;
        end
        display_pkg::grp_states:
        begin
          word_d[31:0]  = status.unit_state;   // unit i at 4i+3:4i
          word_d[36:32] = status.main_state;
        end
        display_pkg::grp_xtouch_ea:
          word_d = status.xtouch_ea;
        display_pkg::grp_cmd_info:
        begin
          if (status.format_alt)
          begin
            word_d[55:40] = status.cmd_length;
            word_d[39:32] = status.cmd_extra;
            word_d[9:0]   = status.cmd_pasid;
          end
          else
          begin
            word_d[57:48] = status.cmd_pasid;
            word_d[31:24] = status.cmd_extra;
            word_d[23:8]  = status.cmd_length;
          end
        end
        display_pkg::grp_atomic_op1:
          word_d = status.atomic_op1;
        display_pkg::grp_cpy_st_ea:
          word_d[63:6] = status.cpy_st_ea;     // low 6 bits stay zero
        display_pkg::grp_dest_ea:
          word_d = status.dest_ea;
        default:
          word_d = '0;                         // grp_zero and addr above 7
      endcase
    end
  end

  // loaded every cycle, held value is don't care outside rddataval
  always_ff @(posedge clock)
  begin
    if (!reset)
      display_data <= '0;
    else
      display_data <= word_d;
  end

  // both strobes come from one sequencer row, never together
  a_capture_exclusive: assert property (
    @(posedge clock) disable iff (!reset) !(rtry_capture && latch_capture)
  );

endmodule

/* logic/display_pkg.sv */
// display unit shared definitions
package display_pkg;

  // ----------------------------------------
  // sizes and field widths
  // ----------------------------------------
  localparam int NUM_UNITS         = 8;   // sub-sequencers in the engine
  localparam int MAIN_STATE_WIDTH  = 5;
  localparam int RESP_CODE_WIDTH   = 4;
  localparam int PENDING_CNT_WIDTH = 5;
  localparam int PASID_WIDTH       = 10;
  localparam int LENGTH_WIDTH      = 16;
  localparam int EXTRA_WIDTH       = 8;

  typedef logic [63:0] display_word_t;   // word handed back to mmio
  typedef logic [63:0] ea_t;             // effective address
  typedef logic [3:0]  unit_state_t;     // one sub-sequencer state
  typedef logic [10:0] rtry_ptr_t;       // retry queue pointer
  typedef logic [17:0] rtry_entry_t;     // retry queue entry
  typedef logic [9:0]  display_addr_t;

  // ----------------------------------------
  // enums
  // ----------------------------------------
  // one-hot sequencer encoding
  typedef enum logic [4:0] {
    st_idle      = 5'b00001,  // wait for read request
    st_wait      = 5'b00010,  // misc requester busy
    st_req       = 5'b00100,  // dbuf only, delayed rden
    st_wt4gnt    = 5'b01000,  // wait for misc arb grant
    st_rddataval = 5'b10000   // word on the bus, valid out
  } seq_state_t;

  typedef enum logic [1:0] {
    ary_dbuf       = 2'd0,
    ary_rtry_queue = 2'd1,
    ary_latch      = 2'd2,
    ary_latch_alt  = 2'd3   // same as ary_latch
  } ary_select_t;

  // low address bits pick the latch group
  typedef enum logic [4:0] {
    grp_status     = 5'd0,
    grp_states     = 5'd1,
    grp_zero       = 5'd2,  // hole, reads zero
    grp_xtouch_ea  = 5'd3,
    grp_cmd_info   = 5'd4,
    grp_atomic_op1 = 5'd5,
    grp_cpy_st_ea  = 5'd6,
    grp_dest_ea    = 5'd7
  } latch_group_t;

  // current work element command
  typedef enum logic [2:0] {
    cmd_none,
    cmd_intrpt,
    cmd_wkhstthrd,
    cmd_atomic_ld,
    cmd_atomic_st,
    cmd_atomic_cas
  } cmd_kind_t;

endpackage

/* logic/display_sequencer.sv */
`timescale 1ns/10ps
// display request sequencer
module display_sequencer #(
  parameter int MISC_ACTIVITY_WIDTH = 19
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              display_rdval,
  input  display_pkg::ary_select_t          ary_select,
  input  display_pkg::display_addr_t        addr,
  input  logic [MISC_ACTIVITY_WIDTH-1:0]    misc_activity,
  input  logic                              arb_gnt,
  output logic                              display_req,
  output logic                              dbuf_rden,
  output logic                              dbuf_rden_dly1,
  output logic                              rtry_queue_rden,
  output logic                              rtry_capture,
  output logic                              latch_capture,
  output logic                              display_valid,
  output display_pkg::latch_group_t         latch_group,
  output display_pkg::display_addr_t        display_addr_q
);

  display_pkg::seq_state_t  state_q;
  display_pkg::seq_state_t  state_d;
  display_pkg::ary_select_t ary_select_q;
  logic                     rdval_q;
  logic                     blocker;
  logic [9:0]               seq_sel;
  logic [11:0]              seq_out;

  // ----------------------------------------
  // request capture
  // ----------------------------------------
  always_ff @(posedge clock)
  begin
    if (!reset)
    begin
      rdval_q        <= 1'b0;
      ary_select_q   <= display_pkg::ary_dbuf;
      display_addr_q <= '0;
    end
    else
    begin
      rdval_q <= display_rdval;
      if (display_rdval)  // select and addr held until next request
      begin
        ary_select_q   <= ary_select;
        display_addr_q <= addr;
      end
    end
  end

  assign latch_group = display_pkg::latch_group_t'(display_addr_q[4:0]);

  // any other misc requester in flight blocks the arb request
  assign blocker = |misc_activity;

  // ----------------------------------------
  // sequencer table
  // ----------------------------------------
  assign seq_sel = {rdval_q, blocker, ary_select_q, arb_gnt, state_q};

  // sel: start, blocker, select[1:0], gnt, state[4:0]
  // out: req, dbuf_rden, dly1, rtry_rden, rtry_cap, latch_cap, valid, next[4:0]
  always_comb
  begin
    casez (seq_sel)
      10'b0????_00001: seq_out = 12'b0000000_00001;  // idle, no request
      10'b11???_00001: seq_out = 12'b0000000_00010;  // blocked, go wait
      10'b1000?_00001: seq_out = 12'b1100000_00100;  // dbuf: req + rden
      10'b1001?_00001: seq_out = 12'b1001000_01000;  // rtry: req + rden
      10'b101??_00001: seq_out = 12'b1000000_01000;  // latch: req only
      // still blocked or blocker cleared
      10'b?1???_00010: seq_out = 12'b0000000_00010;
      10'b?000?_00010: seq_out = 12'b1100000_00100;
      10'b?001?_00010: seq_out = 12'b1001000_01000;
      10'b?01??_00010: seq_out = 12'b1000000_01000;
      // dbuf data rides the cpy_st path, needs the delayed rden
      10'b?????_00100: seq_out = 12'b0010000_01000;
      // grant ignored everywhere but here
      10'b??000_01000: seq_out = 12'b0000000_01000;  // dbuf wait
      10'b??010_01000: seq_out = 12'b0001000_01000;  // rtry wait, hold rden
      10'b??1?0_01000: seq_out = 12'b0000000_01000;  // latch wait
      10'b??001_01000: seq_out = 12'b0000000_10000;  // dbuf gnt, word zero
      10'b??011_01000: seq_out = 12'b0000100_10000;  // rtry gnt, capture entry
      10'b??1?1_01000: seq_out = 12'b0000010_10000;  // latch gnt, capture group
      10'b?????_10000: seq_out = 12'b0000001_00001;  // valid out, back to idle
      // any non one-hot code recovers to idle with strobes low
      default:         seq_out = 12'b0000000_00001;
    endcase
  end

  assign {display_req, dbuf_rden, dbuf_rden_dly1, rtry_queue_rden} = seq_out[11:8];
  assign {rtry_capture, latch_capture, display_valid} = seq_out[7:5];
  assign state_d = display_pkg::seq_state_t'(seq_out[4:0]);

  always_ff @(posedge clock)
  begin
    if (!reset)
      state_q <= display_pkg::st_idle;
    else
      state_q <= state_d;
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------
  a_state_onehot: assert property (
    @(posedge clock) disable iff (!reset) $onehot(state_q)
  );

  // one request in flight, next one only once idle again
  a_rdval_when_idle: assert property (
    @(posedge clock) disable iff (!reset)
    display_rdval |-> (state_q == display_pkg::st_idle) && !rdval_q
  );

endmodule

/* logic/engine_display.sv */
`timescale 1ns/10ps
// engine debug display unit
module engine_display #(
  parameter int MISC_ACTIVITY_WIDTH = 19
) (
  input  logic                                              clock,
  input  logic                                              reset,
  // read request from mmio
  input  logic                                              display_rdval,
  input  display_pkg::ary_select_t                          display_ary_select,
  input  display_pkg::display_addr_t                        display_addr,
  input  logic [MISC_ACTIVITY_WIDTH-1:0]                    misc_activity,
  input  logic                                              arb_gnt,
  // engine status
  input  logic [display_pkg::NUM_UNITS-1:0]                 unit_idle,
  input  logic [display_pkg::NUM_UNITS-1:0]                 unit_wt4rsp,
  input  display_pkg::unit_state_t [display_pkg::NUM_UNITS-1:0] unit_state,
  input  logic [display_pkg::MAIN_STATE_WIDTH-1:0]          main_state,
  input  display_pkg::cmd_kind_t                            cmd_kind,
  input  display_pkg::rtry_entry_t                          rtry_queue_rddata,
  input  logic [display_pkg::RESP_CODE_WIDTH-1:0]           resp_code,
  input  logic [display_pkg::PENDING_CNT_WIDTH-1:0]         pending_cnt,
  input  logic                                              rtry_queue_rden_blocker,
  input  display_pkg::rtry_ptr_t                            rtry_queue_rdaddr,
  input  display_pkg::rtry_ptr_t                            rtry_queue_wraddr,
  input  logic [display_pkg::PASID_WIDTH-1:0]               cmd_pasid,
  input  logic [display_pkg::LENGTH_WIDTH-1:0]              cmd_length,
  input  logic [display_pkg::EXTRA_WIDTH-1:0]               cmd_extra,
  input  logic                                              format_alt,
  input  display_pkg::ea_t                                  xtouch_ea,
  input  display_pkg::ea_t                                  atomic_op1,
  input  logic [63:6]                                       cpy_st_ea,
  input  display_pkg::ea_t                                  dest_ea,
  // strobes and result
  output logic                                              display_req,
  output logic                                              dbuf_rden,
  output logic                                              dbuf_rden_dly1,
  output logic                                              rtry_queue_rden,
  output logic                                              display_valid,
  output display_pkg::display_addr_t                        display_addr_q,
  output display_pkg::display_word_t                        display_data
);

  logic                      rtry_capture;
  logic                      latch_capture;
  display_pkg::latch_group_t latch_group;

  engine_status_if status_if ();

  // ----------------------------------------
  // status snapshot into the bundle
  // ----------------------------------------
  assign status_if.unit_idle               = unit_idle;
  assign status_if.unit_wt4rsp             = unit_wt4rsp;
  assign status_if.unit_state              = unit_state;
  assign status_if.main_state              = main_state;
  assign status_if.cmd_kind                = cmd_kind;
  assign status_if.rtry_queue_rddata       = rtry_queue_rddata;
  assign status_if.resp_code               = resp_code;
  assign status_if.pending_cnt             = pending_cnt;
  assign status_if.rtry_queue_rden_blocker = rtry_queue_rden_blocker;
  assign status_if.rtry_queue_rdaddr       = rtry_queue_rdaddr;
  assign status_if.rtry_queue_wraddr       = rtry_queue_wraddr;
  assign status_if.cmd_pasid               = cmd_pasid;
  assign status_if.cmd_length              = cmd_length;
  assign status_if.cmd_extra               = cmd_extra;
  assign status_if.format_alt              = format_alt;
  assign status_if.xtouch_ea               = xtouch_ea;
  assign status_if.atomic_op1              = atomic_op1;
  assign status_if.cpy_st_ea               = cpy_st_ea;
  assign status_if.dest_ea                 = dest_ea;

  display_sequencer #(
    .MISC_ACTIVITY_WIDTH (MISC_ACTIVITY_WIDTH)
  ) display_sequencer_i (
    .clock           (clock),
    .reset           (reset),
    .display_rdval   (display_rdval),
    .ary_select      (display_ary_select),
    .addr            (display_addr),
    .misc_activity   (misc_activity),
    .arb_gnt         (arb_gnt),
    .display_req     (display_req),
    .dbuf_rden       (dbuf_rden),
    .dbuf_rden_dly1  (dbuf_rden_dly1),
    .rtry_queue_rden (rtry_queue_rden),
    .rtry_capture    (rtry_capture),
    .latch_capture   (latch_capture),
    .display_valid   (display_valid),
    .latch_group     (latch_group),
    .display_addr_q  (display_addr_q)
  );

  // word lands one cycle after the capture strobe, with display_valid
  display_data_select display_data_select_i (
    .clock         (clock),
    .reset         (reset),
    .status        (status_if.sink),
    .rtry_capture  (rtry_capture),
    .latch_capture (latch_capture),
    .latch_group   (latch_group),
    .display_data  (display_data)
  );

endmodule

/* logic/engine_status_if.sv */
`timescale 1ns/10ps
// engine status snapshot bundle
interface engine_status_if;

  // per-unit sequencer flags, unit 0 in the low bits
  logic [display_pkg::NUM_UNITS-1:0] unit_idle;
  logic [display_pkg::NUM_UNITS-1:0] unit_wt4rsp;
  display_pkg::unit_state_t [display_pkg::NUM_UNITS-1:0] unit_state;

  logic [display_pkg::MAIN_STATE_WIDTH-1:0] main_state;
  display_pkg::cmd_kind_t cmd_kind;

  // retry queue side
  display_pkg::rtry_entry_t rtry_queue_rddata;
  logic [display_pkg::RESP_CODE_WIDTH-1:0] resp_code;
  logic [display_pkg::PENDING_CNT_WIDTH-1:0] pending_cnt;
  logic rtry_queue_rden_blocker;
  display_pkg::rtry_ptr_t rtry_queue_rdaddr;
  display_pkg::rtry_ptr_t rtry_queue_wraddr;

  // command info
  logic [display_pkg::PASID_WIDTH-1:0] cmd_pasid;
  logic [display_pkg::LENGTH_WIDTH-1:0] cmd_length;
  logic [display_pkg::EXTRA_WIDTH-1:0] cmd_extra;
  logic format_alt;                       // alternate cmd info layout

  display_pkg::ea_t xtouch_ea;
  display_pkg::ea_t atomic_op1;
  logic [63:6] cpy_st_ea;                 // 64B aligned
  display_pkg::ea_t dest_ea;

  modport source (
    output unit_idle, unit_wt4rsp, unit_state, main_state, cmd_kind,
    output rtry_queue_rddata, resp_code, pending_cnt, rtry_queue_rden_blocker,
    output rtry_queue_rdaddr, rtry_queue_wraddr,
    output cmd_pasid, cmd_length, cmd_extra, format_alt,
    output xtouch_ea, atomic_op1, cpy_st_ea, dest_ea
  );

  modport sink (
    input unit_idle, unit_wt4rsp, unit_state, main_state, cmd_kind,
    input rtry_queue_rddata, resp_code, pending_cnt, rtry_queue_rden_blocker,
    input rtry_queue_rdaddr, rtry_queue_wraddr,
    input cmd_pasid, cmd_length, cmd_extra, format_alt,
    input xtouch_ea, atomic_op1, cpy_st_ea, dest_ea
  );

endinterface

/* run_sim.sh */
#!/bin/sh
# build and run the engine display testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module engine_display_tb \
  -o engine_display_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/engine_display_sim > sim.log 2>&1 || echo "simulator exited with nonzero status"

grep -q "TB FAILED" sim.log && { echo "simulation reported failure, see sim.log"; exit 1; } \
  || grep -q "TB PASSED" sim.log \
  || { echo "no pass message in sim.log"; exit 1; }

echo "simulation passed"

/* sources.f */
+incdir+tb
logic/display_pkg.sv
logic/engine_status_if.sv
logic/display_sequencer.sv
logic/display_data_select.sv
logic/engine_display.sv
tb/engine_display_tb.sv

/* tb/display_model.svh */
// display expected-word model
`ifndef DISPLAY_MODEL_SVH
`define DISPLAY_MODEL_SVH

// one stimulus row
typedef struct {
  display_pkg::ary_select_t   sel;
  display_pkg::display_addr_t addr;
  bit                         fmt_alt;
  int                         hold;       // cycles misc_activity stays busy
  int                         gnt_delay;  // cycles from display_req to grant
} stim_row_t;

// engine status as driven onto the DUT
typedef struct {
  logic [7:0]               unit_idle;
  logic [7:0]               unit_wt4rsp;
  logic [31:0]              unit_state;
  logic [4:0]               main_state;
  display_pkg::cmd_kind_t   cmd_kind;
  display_pkg::rtry_entry_t rddata;
  logic [3:0]               resp_code;
  logic [4:0]               pending_cnt;
  logic                     blocker;
  display_pkg::rtry_ptr_t   rdaddr;
  display_pkg::rtry_ptr_t   wraddr;
  logic [9:0]               pasid;
  logic [15:0]              length;
  logic [7:0]               extra;
  logic                     fmt_alt;
  display_pkg::ea_t         xtouch_ea;
  display_pkg::ea_t         atomic_op1;
  logic [63:6]              cpy_st_ea;
  display_pkg::ea_t         dest_ea;
} status_snap_t;

// bit n-1 for the n-th command kind
function automatic logic [4:0] cmd_flags(display_pkg::cmd_kind_t k);
  if (k == display_pkg::cmd_none)
    return 5'b0;
  return 5'(1 << (int'(k) - 1));
endfunction

function automatic display_pkg::display_word_t rtry_word(status_snap_t s);
  display_pkg::display_word_t w;
  w = '0;
  w[29:28] = s.rddata[17:16];
  w[27]    = s.blocker;
  w[24:20] = s.pending_cnt;
  w[19:16] = s.resp_code;
  w[15:0]  = s.rddata[15:0];
  return w;
endfunction

function automatic display_pkg::display_word_t latch_word(display_pkg::display_addr_t addr,
                                                           status_snap_t s);
  display_pkg::display_word_t w;
  w = '0;
  case (addr[4:0])
    5'd0:
    begin
      w[63:53] = s.wraddr;
      w[52:42] = s.rdaddr;
      w[41]    = (s.pending_cnt != 5'd0);
      w[40]    = s.blocker;
      w[39:32] = ~s.unit_idle;
      w[31:24] = s.unit_wt4rsp;
      w[4:0]   = cmd_flags(s.cmd_kind);
    end
    5'd1:
    begin
      for (int i = 0; i < 8; i++)
        w[4*i +: 4] = s.unit_state[4*i +: 4];
      w[36:32] = s.main_state;
    end
    5'd3: w = s.xtouch_ea;
    5'd4:
    begin
      if (s.fmt_alt)
      begin
        w[55:40] = s.length;
        w[39:32] = s.extra;
        w[9:0]   = s.pasid;
      end
      else
      begin
        w[57:48] = s.pasid;
        w[31:24] = s.extra;
        w[23:8]  = s.length;
      end
    end
    5'd5: w = s.atomic_op1;
    5'd6: w[63:6] = s.cpy_st_ea;
    5'd7: w = s.dest_ea;
    default: w = '0;  // group 2 and the rest
  endcase
  return w;
endfunction

function automatic display_pkg::display_word_t expected_word(stim_row_t row, status_snap_t s);
  if (row.sel == display_pkg::ary_dbuf)
    return '0;
  if (row.sel == display_pkg::ary_rtry_queue)
    return rtry_word(s);
  return latch_word(row.addr, s);
endfunction

`endif

/* tb/engine_display_tb.sv */
`timescale 1ns/10ps
// engine display testbench
module engine_display_tb;

  `include "display_model.svh"

  localparam int NUM_ROWS  = 16;
  localparam int MAX_CYCLE = NUM_ROWS * 20 + 10;

  logic                       clock;
  logic                       reset;
  logic                       display_rdval;
  display_pkg::ary_select_t   display_ary_select;
  display_pkg::display_addr_t display_addr;
  logic [18:0]                misc_activity;
  logic                       arb_gnt;
  status_snap_t               snap;
  logic                       display_req;
  logic                       dbuf_rden;
  logic                       dbuf_rden_dly1;
  logic                       rtry_queue_rden;
  logic                       display_valid;
  display_pkg::display_addr_t display_addr_q;
  display_pkg::display_word_t display_data;

  stim_row_t table_rows [NUM_ROWS];
  int        errors = 0;
  int        bad_rows = 0;
  int        cycles = 0;

  engine_display #(.MISC_ACTIVITY_WIDTH (19)) engine_display_i (
    .clock (clock), .reset (reset),
    .display_rdval (display_rdval), .display_ary_select (display_ary_select),
    .display_addr (display_addr), .misc_activity (misc_activity), .arb_gnt (arb_gnt),
    .unit_idle (snap.unit_idle), .unit_wt4rsp (snap.unit_wt4rsp),
    .unit_state (snap.unit_state), .main_state (snap.main_state),
    .cmd_kind (snap.cmd_kind), .rtry_queue_rddata (snap.rddata),
    .resp_code (snap.resp_code), .pending_cnt (snap.pending_cnt),
    .rtry_queue_rden_blocker (snap.blocker), .rtry_queue_rdaddr (snap.rdaddr),
    .rtry_queue_wraddr (snap.wraddr), .cmd_pasid (snap.pasid),
    .cmd_length (snap.length), .cmd_extra (snap.extra), .format_alt (snap.fmt_alt),
    .xtouch_ea (snap.xtouch_ea), .atomic_op1 (snap.atomic_op1),
    .cpy_st_ea (snap.cpy_st_ea), .dest_ea (snap.dest_ea),
    .display_req (display_req), .dbuf_rden (dbuf_rden),
    .dbuf_rden_dly1 (dbuf_rden_dly1), .rtry_queue_rden (rtry_queue_rden),
    .display_valid (display_valid), .display_addr_q (display_addr_q),
    .display_data (display_data)
  );

  always #50 clock = ~clock;  // 100 ns period

  // run limit
  always @(posedge clock)
  begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLE)
    begin
      $display("timeout after %0d cycles, display_valid never came", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [63:0] rand64();
    return {$urandom(), $urandom()};
  endfunction

  function automatic status_snap_t random_snap();
    status_snap_t s;
    logic [63:0]  r;
    int           k;
    r = rand64();
    s.unit_idle   = r[7:0];
    s.unit_wt4rsp = r[15:8];
    s.unit_state  = r[63:32];
    s.main_state  = r[20:16];
    s.resp_code   = r[24:21];
    s.pending_cnt = r[29:25];
    s.blocker     = r[30];
    s.fmt_alt     = r[31];
    r = rand64();
    s.rddata = r[17:0];
    s.rdaddr = r[28:18];
    s.wraddr = r[39:29];
    s.pasid  = r[49:40];
    s.extra  = r[57:50];
    s.length = r[63:48];
    k = $urandom_range(5, 0);
    s.cmd_kind   = display_pkg::cmd_kind_t'(k[2:0]);
    s.xtouch_ea  = rand64();
    s.atomic_op1 = rand64();
    r = rand64();
    s.cpy_st_ea  = r[63:6];
    s.dest_ea    = rand64();
    return s;
  endfunction

  // ----------------------------------------
  // compare tasks
  // ----------------------------------------
  task automatic check_word(string name, display_pkg::display_word_t got,
                            display_pkg::display_word_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, display_pkg::display_addr_t got,
                            display_pkg::display_addr_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_strobe(string name, logic got, logic exp);
    if (got !== exp)
    begin
      errors++;
      $display("MISMATCH t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  task automatic check_quiet();
    check_strobe("display_req", display_req, 1'b0);
    check_strobe("dbuf_rden", dbuf_rden, 1'b0);
    check_strobe("dbuf_rden_dly1", dbuf_rden_dly1, 1'b0);
    check_strobe("rtry_queue_rden", rtry_queue_rden, 1'b0);
    check_strobe("display_valid", display_valid, 1'b0);
  endtask

  // ----------------------------------------
  // one request, arbiter model inline
  // ----------------------------------------
  task automatic run_row(int idx);
    stim_row_t                  row;
    status_snap_t               s;
    display_pkg::display_word_t exp_word;
    logic [31:0]                r;
    int                         n;
    int                         left;
    int                         req_count;
    int                         err_start;
    bit                         pending;
    bit                         in_window;
    bit                         prev_dbuf;
    bit                         gnt_next;
    bit                         done;
    bit                         is_dbuf;
    bit                         is_rtry;
    row = table_rows[idx];
    s = random_snap();
    s.fmt_alt = row.fmt_alt;
    exp_word = expected_word(row, s);
    is_dbuf = (row.sel == display_pkg::ary_dbuf);
    is_rtry = (row.sel == display_pkg::ary_rtry_queue);
    r = $urandom();
    err_start = errors;
    n = 0;
    left = 0;
    req_count = 0;
    pending = 0;
    in_window = 0;
    prev_dbuf = 0;
    gnt_next = 0;
    done = 0;
    @(posedge clock);
    snap <= s;
    // one busy requester, on any bit of the vector
    misc_activity <= (row.hold > 0) ? (19'd1 << (r % 19)) : 19'd0;
    display_rdval <= 1'b1;
    display_ary_select <= row.sel;
    display_addr <= row.addr;
    @(posedge clock);
    display_rdval <= 1'b0;
    // request fields move on, the DUT keeps its own copy
    display_ary_select <= display_pkg::ary_select_t'(~row.sel);
    display_addr <= ~row.addr;
    while (!done)
    begin
      @(negedge clock);
      if (n < row.hold)
        check_strobe("display_req", display_req, 1'b0);  // blocked
      check_strobe("dbuf_rden", dbuf_rden, is_dbuf && display_req);
      check_strobe("dbuf_rden_dly1", dbuf_rden_dly1, prev_dbuf);
      check_strobe("rtry_queue_rden", rtry_queue_rden,
                   is_rtry && (display_req || (in_window && !arb_gnt)));
      prev_dbuf = dbuf_rden;
      if (display_req)
      begin
        req_count++;
        in_window = 1;
        pending = 1;
        left = row.gnt_delay;
      end
      else
      begin
        if (arb_gnt)
          in_window = 0;
        if (pending && left == 0)
          gnt_next = 1;
        else if (pending)
          left--;
      end
      if (display_valid)
      begin
        check_word("display_data", display_data, exp_word);
        check_addr("display_addr_q", display_addr_q, row.addr);
        if (req_count != 1)
        begin
          errors++;
          $display("display_req pulsed %0d times in row %0d, expected once", req_count, idx);
        end
        gnt_next = 0;
        done = 1;
      end
      @(posedge clock);
      arb_gnt <= gnt_next;
      if (n + 1 >= row.hold)
        misc_activity <= '0;
      n++;
    end
    @(negedge clock);
    check_quiet();  // single valid, nothing left behind
    if (errors != err_start)
      bad_rows++;
    $display("row %0d sel %0d addr %h hold %0d delay %0d: %s", idx, row.sel, row.addr,
             row.hold, row.gnt_delay, (errors == err_start) ? "ok" : "errors");
  endtask

  initial
  begin
    void'($urandom(32'h58f1));
    clock = 1'b0;
    reset <= 1'b0;
    display_rdval <= 1'b0;
    display_ary_select <= display_pkg::ary_dbuf;
    display_addr <= '0;
    misc_activity <= '0;
    arb_gnt <= 1'b0;
    snap <= random_snap();
    // sel, addr, format_alt, blocker hold, grant delay
    table_rows[0]  = '{display_pkg::ary_dbuf,       10'h2a5, 1'b0, 0, 2};
    table_rows[1]  = '{display_pkg::ary_dbuf,       10'h013, 1'b0, 3, 0};
    table_rows[2]  = '{display_pkg::ary_rtry_queue, 10'h011, 1'b0, 0, 3};
    table_rows[3]  = '{display_pkg::ary_rtry_queue, 10'h3c0, 1'b0, 2, 0};
    table_rows[4]  = '{display_pkg::ary_latch,      10'h000, 1'b0, 0, 1};
    table_rows[5]  = '{display_pkg::ary_latch_alt,  10'h001, 1'b0, 1, 4};
    table_rows[6]  = '{display_pkg::ary_latch,      10'h002, 1'b0, 0, 0};
    table_rows[7]  = '{display_pkg::ary_latch_alt,  10'h003, 1'b0, 0, 5};
    table_rows[8]  = '{display_pkg::ary_latch,      10'h004, 1'b0, 0, 2};
    table_rows[9]  = '{display_pkg::ary_latch_alt,  10'h004, 1'b1, 4, 1};
    table_rows[10] = '{display_pkg::ary_latch,      10'h005, 1'b1, 0, 0};
    table_rows[11] = '{display_pkg::ary_latch,      10'h006, 1'b0, 0, 3};
    table_rows[12] = '{display_pkg::ary_latch,      10'h007, 1'b0, 2, 2};
    table_rows[13] = '{display_pkg::ary_latch,      10'h008, 1'b0, 0, 1};
    table_rows[14] = '{display_pkg::ary_latch_alt,  10'h3ff, 1'b1, 0, 0};
    table_rows[15] = '{display_pkg::ary_latch,      10'h3f0, 1'b1, 1, 2};
    repeat (2)
    begin
      @(negedge clock);
      check_quiet();  // held in reset
    end
    @(posedge clock);
    reset <= 1'b1;
    repeat (2)
    begin
      @(negedge clock);
      check_quiet();
      check_addr("display_addr_q", display_addr_q, '0);
    end
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    $display("rows %0d, rows with errors %0d, errors %0d", NUM_ROWS, bad_rows, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule
